// ==== compile.f ====
rtl/afifo_pkg.sv
rtl/afifo_ram.sv
rtl/afifo_wrctl.sv
rtl/afifo_rdctl.sv
rtl/afifo_top.sv
sim/afifo_tb.sv

// ==== rtl/afifo_pkg.sv ====
// ----------------------------------------------------------
// shared types, constants and pointer helpers for the
// dual-clock FIFO, imported by the controllers and top level
// ----------------------------------------------------------
`default_nettype none

package afifo_pkg;

   // payload word carried across the clock boundary
   typedef struct packed {
      logic [3:0]  tag;
      logic [15:0] data;
   } afifo_word_t;

   // default address width, 8 entries
   localparam int AFIFO_PTR_WIDTH_DEF = 3;

   // widest pointer the helpers handle, incl. wrap bit
   localparam int AFIFO_PTR_MAX = 16;
   typedef logic [AFIFO_PTR_MAX-1:0] afifo_ptr_t;

   // flag values while in reset
   localparam logic AFIFO_EMPTY_RST = 1'b1;
   localparam logic AFIFO_FULL_RST  = 1'b0;

   // binary to gray, zero-extended input is fine
   function automatic afifo_ptr_t afifo_bin2gray(input afifo_ptr_t b);
      return b ^ (b >> 1);
   endfunction

   // gray to binary, running xor from the msb down
   function automatic afifo_ptr_t afifo_gray2bin(input afifo_ptr_t g);
      afifo_ptr_t b;
      b[AFIFO_PTR_MAX-1] = g[AFIFO_PTR_MAX-1];
      for (int i = AFIFO_PTR_MAX - 2; i >= 0; i--)
      begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

endpackage

`default_nettype wire

// ==== rtl/afifo_ram.sv ====
// ----------------------------------------------------------
// dual-clock storage array, write on wclk, registered read
// on rclk, word type set by the instantiating module
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module afifo_ram #(
   parameter int  PTR_WIDTH = 3,
   parameter type word_t    = logic [7:0]
) (
   input  wire logic                 wclk,
   input  wire logic                 we,
   input  wire logic [PTR_WIDTH-1:0] waddr,
   input  word_t                     wdata,
   input  wire logic                 rclk,
   input  wire logic                 re,
   input  wire logic [PTR_WIDTH-1:0] raddr,
   output word_t                     rdata
);

   localparam int ENTRIES = 2 ** PTR_WIDTH;

   word_t mem [ENTRIES];

   // write port, wclk domain
   always_ff @(posedge wclk)
   begin
      if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // read port, holds last word when idle
   always_ff @(posedge rclk)
   begin
      if (re)
      begin
         rdata <= mem[raddr];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/afifo_rdctl.sv ====
// ----------------------------------------------------------
// read-domain controller, owns the read pointer, depth,
// empty, the RAM read strobe, data valid and flush
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module afifo_rdctl #(
   parameter int PTR_WIDTH = afifo_pkg::AFIFO_PTR_WIDTH_DEF
) (
   input  wire logic                 rclk,
   input  wire logic                 rreset,
   input  wire logic                 pop,
   input  wire logic                 flush,
   input  wire logic [PTR_WIDTH:0]   wr_ptr_gray,
   output logic                      dout_v,
   output logic [PTR_WIDTH:0]        depth,
   output logic                      empty,
   output logic [PTR_WIDTH:0]        rd_ptr_gray,
   output logic                      ram_re,
   output logic [PTR_WIDTH-1:0]      ram_raddr
);

   import afifo_pkg::*;

   logic [PTR_WIDTH:0] wr_gray_d1;
   logic [PTR_WIDTH:0] wr_gray_d2;
   afifo_ptr_t         wr_bin_ext;
   logic [PTR_WIDTH:0] wr_bin_sync;
   logic [PTR_WIDTH:0] rd_bin_q;
   logic [PTR_WIDTH:0] rd_bin_next;
   afifo_ptr_t         rd_gray_ext;
   logic [PTR_WIDTH:0] rd_gray_q;
   logic [PTR_WIDTH:0] gap;
   logic [PTR_WIDTH:0] depth_next;
   logic [PTR_WIDTH:0] depth_q;
   logic               empty_next;
   logic               empty_q;
   logic               dout_v_q;
   logic               pop_ok;
   logic               pop_or_flush;

   // ----------------------------------------------------------
   // write pointer into rclk, two flops
   // ----------------------------------------------------------
   always_ff @(posedge rclk or posedge rreset)
   begin
      if (rreset)
      begin
         wr_gray_d1 <= '0;
         wr_gray_d2 <= '0;
      end
      else
      begin
         wr_gray_d1 <= wr_ptr_gray;
         wr_gray_d2 <= wr_gray_d1;
      end
   end

   // decode synced gray pointer
   assign wr_bin_ext  = afifo_gray2bin(afifo_ptr_t'(wr_gray_d2));
   assign wr_bin_sync = wr_bin_ext[PTR_WIDTH:0];

   // ----------------------------------------------------------
   // next-state logic
   // ----------------------------------------------------------
   // pop on empty is ignored
   assign pop_ok       = pop & ~empty_q;
   assign pop_or_flush = pop_ok | flush;

   // words in flight as seen from this side
   assign gap        = wr_bin_sync - rd_bin_q;
   assign depth_next = pop_or_flush ? (gap - 1'b1) : gap;
   assign empty_next = (depth_next == '0);

   // flush jumps to the synced write pointer, dropping contents
   assign rd_bin_next = flush ? wr_bin_sync
                              : (rd_bin_q + {{PTR_WIDTH{1'b0}}, pop_ok});
   assign rd_gray_ext = afifo_bin2gray(afifo_ptr_t'(rd_bin_next));

   // ----------------------------------------------------------
   // state registers
   // ----------------------------------------------------------
   always_ff @(posedge rclk or posedge rreset)
   begin
      if (rreset)
      begin
         dout_v_q  <= 1'b0;
         depth_q   <= '0;
         empty_q   <= AFIFO_EMPTY_RST;
         rd_bin_q  <= '0;
         rd_gray_q <= '0;
      end
      else
      begin
         // RAM word lands one cycle after the strobe
         dout_v_q  <= pop_ok;
         depth_q   <= depth_next;
         empty_q   <= empty_next;
         rd_bin_q  <= rd_bin_next;
         rd_gray_q <= rd_gray_ext[PTR_WIDTH:0];
      end
   end

   // outputs
   assign dout_v      = dout_v_q;
   assign depth       = depth_q;
   assign empty       = empty_q;
   assign rd_ptr_gray = rd_gray_q;
   assign ram_re      = pop_ok;
   assign ram_raddr   = rd_bin_q[PTR_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== rtl/afifo_top.sv ====
// ----------------------------------------------------------
// dual-clock FIFO top, wires both controllers to the array
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module afifo_top #(
   parameter int  PTR_WIDTH = afifo_pkg::AFIFO_PTR_WIDTH_DEF,
   parameter type word_t    = afifo_pkg::afifo_word_t
) (
   // write domain
   input  wire logic                 wclk,
   input  wire logic                 wreset,
   input  wire logic                 push,
   input  word_t                     din,
   output logic                      full,
   // read domain
   input  wire logic                 rclk,
   input  wire logic                 rreset,
   input  wire logic                 pop,
   input  wire logic                 flush,
   output word_t                     dout,
   output logic                      dout_v,
   output logic [PTR_WIDTH:0]        depth,
   output logic                      empty
);

   // cross-domain gray pointers
   logic [PTR_WIDTH:0]   wr_ptr_gray;
   logic [PTR_WIDTH:0]   rd_ptr_gray;
   // array strobes and addresses
   logic                 ram_we;
   logic [PTR_WIDTH-1:0] ram_waddr;
   logic                 ram_re;
   logic [PTR_WIDTH-1:0] ram_raddr;

   afifo_wrctl #(
      .PTR_WIDTH (PTR_WIDTH)
   ) u_wrctl (
      .wclk        (wclk),
      .wreset      (wreset),
      .push        (push),
      .rd_ptr_gray (rd_ptr_gray),
      .full        (full),
      .wr_ptr_gray (wr_ptr_gray),
      .ram_we      (ram_we),
      .ram_waddr   (ram_waddr)
   );

   afifo_rdctl #(
      .PTR_WIDTH (PTR_WIDTH)
   ) u_rdctl (
      .rclk        (rclk),
      .rreset      (rreset),
      .pop         (pop),
      .flush       (flush),
      .wr_ptr_gray (wr_ptr_gray),
      .dout_v      (dout_v),
      .depth       (depth),
      .empty       (empty),
      .rd_ptr_gray (rd_ptr_gray),
      .ram_re      (ram_re),
      .ram_raddr   (ram_raddr)
   );

   // din goes straight into the array
   afifo_ram #(
      .PTR_WIDTH (PTR_WIDTH),
      .word_t    (word_t)
   ) u_ram (
      .wclk  (wclk),
      .we    (ram_we),
      .waddr (ram_waddr),
      .wdata (din),
      .rclk  (rclk),
      .re    (ram_re),
      .raddr (ram_raddr),
      .rdata (dout)
   );

endmodule

`default_nettype wire

// ==== rtl/afifo_wrctl.sv ====
// ----------------------------------------------------------
// write-domain controller, owns the write pointer and full
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module afifo_wrctl #(
   parameter int PTR_WIDTH = afifo_pkg::AFIFO_PTR_WIDTH_DEF
) (
   input  wire logic                 wclk,
   input  wire logic                 wreset,
   input  wire logic                 push,
   input  wire logic [PTR_WIDTH:0]   rd_ptr_gray,
   output logic                      full,
   output logic [PTR_WIDTH:0]        wr_ptr_gray,
   output logic                      ram_we,
   output logic [PTR_WIDTH-1:0]      ram_waddr
);

   import afifo_pkg::*;

   // pointer gap when every entry holds a word
   localparam logic [PTR_WIDTH:0] FIFO_SIZE = {1'b1, {PTR_WIDTH{1'b0}}};

   logic [PTR_WIDTH:0] rd_gray_d1;
   logic [PTR_WIDTH:0] rd_gray_d2;
   afifo_ptr_t         rd_bin_ext;
   logic [PTR_WIDTH:0] rd_bin_sync;
   logic [PTR_WIDTH:0] wr_bin_q;
   logic [PTR_WIDTH:0] wr_bin_next;
   afifo_ptr_t         wr_gray_ext;
   logic [PTR_WIDTH:0] wr_gray_q;
   logic [PTR_WIDTH:0] gap_next;
   logic               full_q;

   // ----------------------------------------------------------
   // read pointer into wclk, two flops
   // ----------------------------------------------------------
   always_ff @(posedge wclk or posedge wreset)
   begin
      if (wreset)
      begin
         rd_gray_d1 <= '0;
         rd_gray_d2 <= '0;
      end
      else
      begin
         rd_gray_d1 <= rd_ptr_gray;
         rd_gray_d2 <= rd_gray_d1;
      end
   end

   // decode synced gray pointer
   assign rd_bin_ext  = afifo_gray2bin(afifo_ptr_t'(rd_gray_d2));
   assign rd_bin_sync = rd_bin_ext[PTR_WIDTH:0];

   // ----------------------------------------------------------
   // write pointer and full flag
   // ----------------------------------------------------------
   // accepted push only, push while full is lost
   assign ram_we      = push & ~full_q;
   assign wr_bin_next = wr_bin_q + {{PTR_WIDTH{1'b0}}, ram_we};
   assign wr_gray_ext = afifo_bin2gray(afifo_ptr_t'(wr_bin_next));

   // full once the gap reaches the array size
   assign gap_next = wr_bin_next - rd_bin_sync;

   always_ff @(posedge wclk or posedge wreset)
   begin
      if (wreset)
      begin
         wr_bin_q  <= '0;
         wr_gray_q <= '0;
         full_q    <= AFIFO_FULL_RST;
      end
      else
      begin
         wr_bin_q  <= wr_bin_next;
         wr_gray_q <= wr_gray_ext[PTR_WIDTH:0];
         full_q    <= (gap_next == FIFO_SIZE);
      end
   end

   // outputs
   assign full        = full_q;
   assign wr_ptr_gray = wr_gray_q;
   assign ram_waddr   = wr_bin_q[PTR_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the FIFO testbench with Verilator, pass if the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --top-module afifo_tb -f compile.f -o afifo_sim \
      > build.log 2>&1 \
   && ./obj_dir/afifo_sim | tee sim.log \
   && grep -q "^RESULT: PASS$" sim.log \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== sim/afifo_tb.sv ====
// ------------------------------------------------------------
// testbench for the dual-clock FIFO, table rows drive pushes,
// pops and flush, a queue model checks dout, depth and flags
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module afifo_tb;

   import afifo_pkg::*;

   localparam int PTR_WIDTH = AFIFO_PTR_WIDTH_DEF;
   localparam int NROWS     = 10;
   localparam int SETTLE    = 10;

   typedef logic [PTR_WIDTH:0] depth_t;

   // one row, applied as pushes, flush, pops, then checks
   typedef struct packed {
      int pushes;
      int pops;
      bit flush;
      int exp_depth;
      bit exp_empty;
      bit exp_full;
   } row_t;

   localparam row_t ROWS [NROWS] = '{
      '{3, 0, 1'b0, 3, 1'b0, 1'b0},
      '{0, 2, 1'b0, 1, 1'b0, 1'b0},
      // second pop lands on empty
      '{0, 2, 1'b0, 0, 1'b1, 1'b0},
      // 8 fit, 2 dropped while full
      '{10, 0, 1'b0, 8, 1'b0, 1'b1},
      '{0, 8, 1'b0, 0, 1'b1, 1'b0},
      '{5, 0, 1'b0, 5, 1'b0, 1'b0},
      // flush throws the five away
      '{0, 0, 1'b1, 0, 1'b1, 1'b0},
      '{4, 2, 1'b0, 2, 1'b0, 1'b0},
      '{0, 3, 1'b0, 0, 1'b1, 1'b0},
      '{2, 2, 1'b0, 0, 1'b1, 1'b0}
   };

   logic        wclk;
   logic        rclk;
   logic        wreset;
   logic        rreset;
   logic        push;
   logic        pop;
   logic        flush;
   afifo_word_t din;
   afifo_word_t dout;
   logic        dout_v;
   logic        full;
   logic        empty;
   depth_t      depth;

   // words the DUT holds, oldest first
   afifo_word_t model_q [$];
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          limit;
   int unsigned seed_val;

   afifo_top #(
      .PTR_WIDTH (PTR_WIDTH),
      .word_t    (afifo_word_t)
   ) dut (
      .wclk   (wclk),
      .wreset (wreset),
      .push   (push),
      .din    (din),
      .full   (full),
      .rclk   (rclk),
      .rreset (rreset),
      .pop    (pop),
      .flush  (flush),
      .dout   (dout),
      .dout_v (dout_v),
      .depth  (depth),
      .empty  (empty)
   );

   // ----------------------------------------------------------
   // clocks, 40 ns read side and 56 ns write side
   // ----------------------------------------------------------
   initial
   begin
      rclk = 1'b0;
      forever #20 rclk = ~rclk;
   end

   initial
   begin
      wclk = 1'b0;
      forever #28 wclk = ~wclk;
   end

   // ----------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------
   task automatic check_word(input string name, input afifo_word_t got,
                             input afifo_word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s got 0x%05h expected 0x%05h", name, got, exp);
      end
   endtask

   task automatic check_depth(input string name, input depth_t got, input depth_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   // ----------------------------------------------------------
   // stimulus, driven on the falling edge of each clock
   // ----------------------------------------------------------
   // full is stable at the falling edge, so it tells if this push lands
   task automatic push_words(input int n);
      afifo_word_t w;
      logic [31:0] r;
      for (int i = 0; i < n; i++)
      begin
         @(negedge wclk);
         r      = $urandom();
         w.tag  = r[19:16];
         w.data = r[15:0];
         push   = 1'b1;
         din    = w;
         if (!full)
         begin
            model_q.push_back(w);
         end
      end
      @(negedge wclk);
      push = 1'b0;
   endtask

   // back-to-back pops, extra ones meet empty and are ignored
   task automatic pop_words(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(negedge rclk);
         pop = 1'b1;
      end
      @(negedge rclk);
      pop = 1'b0;
   endtask

   task automatic flush_fifo();
      @(negedge rclk);
      flush = 1'b1;
      model_q.delete();
      @(negedge rclk);
      flush = 1'b0;
   endtask

   // lets both pointers cross and flags settle
   task automatic settle();
      repeat (SETTLE) @(negedge rclk);
   endtask

   task automatic apply_row(input int r);
      push_words(ROWS[r].pushes);
      settle();
      if (ROWS[r].flush)
      begin
         flush_fifo();
      end
      pop_words(ROWS[r].pops);
      settle();
      check_depth("depth", depth, depth_t'(ROWS[r].exp_depth));
      check_depth("depth (model)", depth, depth_t'(model_q.size()));
      check_flag("empty", empty, ROWS[r].exp_empty);
      check_flag("empty (model)", empty, model_q.size() == 0);
      check_flag("full", full, ROWS[r].exp_full);
   endtask

   function automatic int total_ops();
      int sum;
      sum = 0;
      for (int r = 0; r < NROWS; r++)
      begin
         sum += ROWS[r].pushes + ROWS[r].pops + int'(ROWS[r].flush);
      end
      return sum;
   endfunction

   // ----------------------------------------------------------
   // output monitor, every valid word must match the model head
   // ----------------------------------------------------------
   initial
   begin
      forever
      begin
         @(negedge rclk);
         if (dout_v)
         begin
            if (model_q.size() == 0)
            begin
               errors++;
               $display("dout_v went high while no word was expected");
            end
            else
            begin
               check_word("dout", dout, model_q.pop_front());
            end
         end
      end
   end

   // run limit scales with the table
   initial
   begin
      limit = 20 * total_ops() + 200;
      while (cycles < limit)
      begin
         @(posedge rclk);
         cycles++;
      end
      $display("timeout, run did not end within %0d rclk cycles", limit);
      $display("RESULT: FAIL");
      $finish;
   end

   // ----------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------
   initial
   begin
      seed_val = $urandom(26);
      wreset   = 1'b1;
      rreset   = 1'b1;
      push     = 1'b0;
      pop      = 1'b0;
      flush    = 1'b0;
      din      = '0;
      repeat (8) @(posedge rclk);
      @(negedge rclk);
      rreset = 1'b0;
      @(negedge wclk);
      wreset = 1'b0;
      settle();
      // state straight out of reset
      check_flag("empty", empty, 1'b1);
      check_depth("depth", depth, '0);
      check_flag("dout_v", dout_v, 1'b0);
      check_flag("full", full, 1'b0);
      for (int r = 0; r < NROWS; r++)
      begin
         apply_row(r);
      end
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
